/* ex_branch_unit.f */
+incdir+verification
hdl/ncpu_ex_pkg.sv
hdl/ex_add.sv
hdl/ex_bru.sv
hdl/ex_result_buf.sv
hdl/ex_ctrl.sv
hdl/ex_branch_unit.sv
verification/tb_ex_branch_unit.sv

/* run.sh */
#!/bin/sh
# Build and run the branch unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module tb_ex_branch_unit -f ex_branch_unit.f
./obj_dir/Vtb_ex_branch_unit > sim.log 2>&1
cat sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
   exit 0
fi
echo "simulation failed, see sim.log"
exit 1

/* verification/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
   return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// Expected outcome of one issued operation
function automatic bru_result_t ref_result(input ex_issue_t op);
   bru_result_t r;
   logic jump;
   logic cond;
   pc_t next_pc;
   r = '0;
   jump = op.opc[bru_jmpreg] | op.opc[bru_jmprel];
   // Six compares, signed ones via $signed
   cond = (op.opc[bru_beq] && (op.operand1 == op.operand2)) ||
          (op.opc[bru_bne] && (op.operand1 != op.operand2)) ||
          (op.opc[bru_bgtu] && (op.operand1 > op.operand2)) ||
          (op.opc[bru_bgt] && ($signed(op.operand1) > $signed(op.operand2))) ||
          (op.opc[bru_bleu] && (op.operand1 <= op.operand2)) ||
          (op.opc[bru_ble] && ($signed(op.operand1) <= $signed(op.operand2)));
   r.pc = op.pc;
   r.taken = cond | jump;
   r.is_bcc = |op.opc[bru_ble:bru_beq];
   r.is_breg = op.opc[bru_jmpreg];
   r.is_brel = op.opc[bru_jmprel];
   // Word targets, zero when not taken
   if (cond) begin
      r.tgt = op.pc + op.imm[addr_w-1:insn_len_log2];
   end else if (op.opc[bru_jmprel]) begin
      r.tgt = op.pc + op.operand2[addr_w-1:insn_len_log2];
   end else if (op.opc[bru_jmpreg]) begin
      r.tgt = op.operand1[addr_w-1:insn_len_log2];
   end
   next_pc = op.pc + pc_t'(1);
   r.link_valid = jump & op.rf_we;
   r.link_data = {next_pc, {insn_len_log2{1'b0}}};
   return r;
endfunction

`endif

/* verification/tb_ex_branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ex_branch_unit
   import ncpu_ex_pkg::*;
();

   localparam int n_cond = 36;
   localparam int n_jump = 8;
   localparam int n_mixed = 40;
   localparam int total_ops = 1 + n_cond + n_jump + n_mixed + 3 + 2;
   // Generous per-op budget plus reset and drain
   localparam int cycle_limit = total_ops * 8 + 200;

   logic clk = 1'b0;
   logic rst_n = 1'b0;
   logic issue_valid = 1'b0;
   ex_issue_t issue = '0;
   logic issue_ready;
   logic result_valid;
   bru_result_t result;
   logic result_ready = 1'b1;
   logic redirect;
   logic flush = 1'b0;

   logic [31:0] lfsr_state = 32'h27bb5f16;
   // Expected results in issue order
   bru_result_t exp_q[$];
   logic wrong_path = 1'b0;
   logic hold_redirect = 1'b0;
   logic rand_ready = 1'b0;
   logic stall_seen = 1'b0;
   int errors = 0;
   int checks = 0;
   int results = 0;
   int squashed = 0;
   int cycles = 0;
   ex_issue_t mixed_ops [n_mixed];

   `include "tb_ref_model.svh"

   ex_branch_unit dut0 (
      .clk(clk),
      .rst_n(rst_n),
      .issue_valid(issue_valid),
      .issue(issue),
      .issue_ready(issue_ready),
      .result_valid(result_valid),
      .result(result),
      .result_ready(result_ready),
      .redirect(redirect),
      .flush(flush)
   );

   // 40 ns period
   always #20 clk = ~clk;

   // One LFSR step per random bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // Sign and range corners for compares
   function automatic data_t edge_value(input logic [31:0] sel);
      case (sel[1:0])
         2'd0: return 32'h7fff_ffff;
         2'd1: return 32'h8000_0000;
         2'd2: return 32'h0000_0000;
         default: return 32'hffff_ffff;
      endcase
   endfunction

   // Kind 8 shifts out of the bus and gives the all-zero opcode
   function automatic ex_issue_t random_op(input int kind);
      ex_issue_t op;
      logic [31:0] r;
      op.opc = bru_opc_t'(32'd1 << kind);
      r = rand_bits(pc_w);
      op.pc = r[pc_w-1:0];
      op.imm = rand_bits(data_w);
      op.operand1 = rand_bits(data_w);
      op.operand2 = rand_bits(data_w);
      r = rand_bits(1);
      op.rf_we = r[0];
      // Equal operands or corner values a quarter of the time each
      r = rand_bits(2);
      if (r[1:0] == 2'd0) begin
         op.operand2 = op.operand1;
      end else if (r[1:0] == 2'd1) begin
         op.operand1 = edge_value(rand_bits(2));
         op.operand2 = edge_value(rand_bits(2));
      end
      return op;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   // Returns at the accepting edge
   task automatic issue_op(input ex_issue_t op);
      issue_valid <= 1'b1;
      issue <= op;
      @(posedge clk);
      while (!issue_ready) begin
         // Low without redirect means back-pressure
         if (!redirect) begin
            stall_seen = 1'b1;
         end
         @(posedge clk);
      end
   endtask

   // Until every result is out and redirect is over
   task automatic wait_idle();
      do begin
         @(posedge clk);
      end while (exp_q.size() != 0 || redirect || result_valid);
   endtask

   task automatic end_test(input string name, input int err_before);
      $display("%s: %0d errors", name, errors - err_before);
   endtask

   // Run limit
   always @(posedge clk) begin
      cycles++;
      if (cycles >= cycle_limit) begin
         $display("Timeout: run did not finish within %0d cycles", cycle_limit);
         $display("** FAIL **");
         $finish;
      end
   end

   // Front end answers redirect with a one-cycle flush
   always @(posedge clk) begin
      if (!rst_n) begin
         flush <= 1'b0;
      end else begin
         flush <= redirect & ~flush & ~hold_redirect;
      end
   end

   // Random back-pressure only in the mixed test
   always @(posedge clk) begin
      if (rand_ready) begin
         result_ready <= (rand_bits(1) != 32'd0);
      end else begin
         result_ready <= 1'b1;
      end
   end

   // Scoreboard on accepting edges
   always @(posedge clk) begin : scoreboard
      bru_result_t e;
      if (rst_n && issue_valid && issue_ready) begin
         if (wrong_path) begin
            // Wrong-path op behind a taken branch
            squashed++;
         end else begin
            e = ref_result(issue);
            exp_q.push_back(e);
            wrong_path = e.taken;
         end
      end else if (flush) begin
         wrong_path = 1'b0;
      end
   end

   // Compare on consuming edges
   always @(posedge clk) begin : compare
      bru_result_t e;
      if (rst_n && result_valid && result_ready) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("Error at %0t ns: result returned with nothing outstanding", $time);
         end else begin
            e = exp_q.pop_front();
            results++;
            check_value("result.pc", 32'(result.pc), 32'(e.pc));
            check_value("result.taken", 32'(result.taken), 32'(e.taken));
            check_value("result.tgt", 32'(result.tgt), 32'(e.tgt));
            check_value("result.is_bcc", 32'(result.is_bcc), 32'(e.is_bcc));
            check_value("result.is_breg", 32'(result.is_breg), 32'(e.is_breg));
            check_value("result.is_brel", 32'(result.is_brel), 32'(e.is_brel));
            check_value("result.link_valid", 32'(result.link_valid), 32'(e.link_valid));
            // Link value only defined with link_valid
            if (e.link_valid) begin
               check_value("result.link_data", result.link_data, e.link_data);
            end
         end
      end
   end

   initial begin
      ex_issue_t op;
      logic [31:0] r;
      int mark;
      int lat;
      rst_n <= 1'b0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);

      // Idle state after reset and two-edge latency
      mark = errors;
      check_value("issue_ready", 32'(issue_ready), 32'd1);
      check_value("result_valid", 32'(result_valid), 32'd0);
      check_value("redirect", 32'(redirect), 32'd0);
      op = random_op(bru_bleu);
      issue_op(op);
      issue_valid <= 1'b0;
      // The accepting edge counts as the first
      lat = 1;
      #1;
      while (!result_valid && lat < 8) begin
         @(posedge clk);
         #1;
         lat++;
      end
      check_value("result latency", 32'(lat), 32'd2);
      wait_idle();
      end_test("test 1 reset and latency", mark);

      // Conditional branches one at a time
      mark = errors;
      for (int i = 0; i < n_cond; i++) begin
         op = random_op(i % 6);
         issue_op(op);
         issue_valid <= 1'b0;
         wait_idle();
      end
      end_test("test 2 conditional branches", mark);

      // Both jumps with link on and off
      mark = errors;
      for (int i = 0; i < n_jump; i++) begin
         op = random_op((i % 2 == 1) ? bru_jmprel : bru_jmpreg);
         op.rf_we = ((i / 2) % 2 == 1);
         issue_op(op);
         issue_valid <= 1'b0;
         wait_idle();
      end
      end_test("test 3 jumps and link", mark);

      // Back-to-back mix under random back-pressure
      mark = errors;
      for (int i = 0; i < n_mixed; i++) begin
         r = rand_bits(4);
         mixed_ops[i] = random_op(int'(r % 32'd9));
      end
      rand_ready <= 1'b1;
      stall_seen = 1'b0;
      for (int i = 0; i < n_mixed; i++) begin
         issue_op(mixed_ops[i]);
      end
      issue_valid <= 1'b0;
      rand_ready <= 1'b0;
      wait_idle();
      check_value("issue_ready low while full", 32'(stall_seen), 32'd1);
      end_test("test 4 back-pressure order", mark);

      // Front end holds flush back while the wrong-path op drops
      mark = errors;
      hold_redirect <= 1'b1;
      op = random_op(bru_beq);
      op.operand2 = op.operand1;
      issue_op(op);
      op = random_op(bru_bne);
      issue_op(op);
      issue_valid <= 1'b0;
      repeat (6) begin
         @(posedge clk);
         check_value("redirect", 32'(redirect), 32'd1);
         check_value("issue_ready", 32'(issue_ready), 32'd0);
      end
      hold_redirect <= 1'b0;
      op = random_op(bru_bgt);
      issue_op(op);
      issue_valid <= 1'b0;
      wait_idle();
      end_test("test 5 redirect and flush", mark);

      // Empty opcode with both rf_we values
      mark = errors;
      for (int i = 0; i < 2; i++) begin
         op = random_op(bru_opc_w);
         op.rf_we = (i == 1);
         issue_op(op);
         issue_valid <= 1'b0;
         wait_idle();
      end
      end_test("test 6 zero opcode", mark);

      $display("Checks %0d, errors %0d, results %0d, squashed %0d",
               checks, errors, results, squashed);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* hdl/ex_branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_branch_unit
   import ncpu_ex_pkg::*;
(
   input wire clk,
   input wire rst_n,
   // Issue port
   input wire issue_valid,
   input wire ex_issue_t issue,
   output logic issue_ready,
   // Result port
   output logic result_valid,
   output bru_result_t result,
   input wire result_ready,
   // Redirect
   output logic redirect,
   input wire flush
);

   ex_issue_t ex_op;
   data_t add_sum;
   logic add_carry;
   logic add_overflow;
   bru_result_t bru_out;
   logic push;
   logic full;

   // Operand register, valid tracking and redirect
   ex_ctrl ctrl0 (
      .clk(clk),
      .rst_n(rst_n),
      .issue_valid(issue_valid),
      .issue(issue),
      .issue_ready(issue_ready),
      .ex_op(ex_op),
      .push(push),
      .full(full),
      .taken(bru_out.taken),
      .flush(flush),
      .redirect(redirect)
   );

   // operand1 - operand2 for the compares
   ex_add add0 (
      .a(ex_op.operand1),
      .b(ex_op.operand2),
      .sum(add_sum),
      .carry(add_carry),
      .overflow(add_overflow)
   );

   // Condition, target and link
   ex_bru bru0 (
      .op(ex_op),
      .sum(add_sum),
      .carry(add_carry),
      .overflow(add_overflow),
      .res(bru_out)
   );

   // Two-entry drain toward the consumer
   ex_result_buf rbuf0 (
      .clk(clk),
      .rst_n(rst_n),
      .push(push),
      .din(bru_out),
      .full(full),
      .result_valid(result_valid),
      .result(result),
      .result_ready(result_ready)
   );

endmodule

`default_nettype wire

/* hdl/ex_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_ctrl
   import ncpu_ex_pkg::*;
(
   input wire clk,
   input wire rst_n,
   // Issue port
   input wire issue_valid,
   input wire ex_issue_t issue,
   output logic issue_ready,
   // Operand register contents
   output ex_issue_t ex_op,
   // Toward the result buffer
   output logic push,
   input wire full,
   // Resolved outcome of ex_op
   input wire taken,
   // Redirect handshake with front end
   input wire flush,
   output logic redirect
);

   ctrl_state_t state;
   ctrl_state_t state_nxt;
   logic ex_valid;
   logic accept;

   assign redirect = (state == ctrl_redirect);

   // Push whenever the buffer has room, never while redirecting
   assign push = ex_valid & ~full & (state == ctrl_run);

   // Register free now or freed at this edge
   assign issue_ready = (state == ctrl_run) & (~ex_valid | push);
   assign accept = issue_valid & issue_ready;

   // Redirect FSM
   always_comb begin
      state_nxt = state;
      case (state)
         ctrl_run: begin
            // Taken branch leaving for the buffer
            if (push & taken) begin
               state_nxt = ctrl_redirect;
            end
         end
         ctrl_redirect: begin
            // Wait for front end
            if (flush) begin
               state_nxt = ctrl_run;
            end
         end
         default: begin
            state_nxt = ctrl_run;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= ctrl_run;
      end else begin
         state <= state_nxt;
      end
   end

   // Operand register valid bit
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_valid <= 1'b0;
      end else if (state == ctrl_redirect) begin
         // Wrong-path op picked up behind the branch
         ex_valid <= 1'b0;
      end else if (accept) begin
         ex_valid <= 1'b1;
      end else if (push) begin
         ex_valid <= 1'b0;
      end
   end

   // Payload, held while the buffer is full
   always_ff @(posedge clk) begin
      if (accept) begin
         ex_op <= issue;
      end
   end

endmodule

`default_nettype wire

/* hdl/ex_result_buf.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_result_buf
   import ncpu_ex_pkg::*;
(
   input wire clk,
   input wire rst_n,
   // Write side from control
   input wire push,
   input wire bru_result_t din,
   output logic full,
   // Result port
   output logic result_valid,
   output bru_result_t result,
   input wire result_ready
);

   // Entry storage
   bru_result_t mem [buf_depth];
   logic rd_ptr;
   logic wr_ptr;
   // Entries held from 0 to 2
   logic [1:0] count;
   logic pop;

   assign result_valid = (count != 2'd0);
   assign pop = result_valid & result_ready;

   // Head entry
   assign result = mem[rd_ptr];

   // A draining entry frees a slot this cycle
   assign full = (count == 2'(buf_depth)) & ~pop;

   // Pointers and occupancy
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_ptr <= 1'b0;
         wr_ptr <= 1'b0;
         count <= 2'd0;
      end else begin
         if (push) begin
            wr_ptr <= ~wr_ptr;
         end
         if (pop) begin
            rd_ptr <= ~rd_ptr;
         end
         // Push and pop together leave count unchanged
         count <= count + 2'(push) - 2'(pop);
      end
   end

   // Write port
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= din;
      end
   end

endmodule

`default_nettype wire

/* hdl/ex_bru.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_bru
   import ncpu_ex_pkg::*;
(
   input wire ex_issue_t op,
   // From the subtractor
   input wire data_t sum,
   input wire carry,
   input wire overflow,
   output bru_result_t res
);

   logic cmp_eq;
   logic cmp_lt_s;
   logic cmp_lt_u;
   logic bcc_taken;
   logic is_jmp;
   pc_t tgt_bcc;
   pc_t tgt_rel;
   pc_t tgt_reg;

   // Comparisons
   assign cmp_eq = (op.operand1 == op.operand2);
   // Sign of difference, corrected by overflow
   assign cmp_lt_s = sum[data_w-1] ^ overflow;
   // Borrow means below
   assign cmp_lt_u = ~carry;

   // Kind flags
   assign res.is_bcc = op.opc[bru_beq] | op.opc[bru_bne] |
                       op.opc[bru_bgtu] | op.opc[bru_bgt] |
                       op.opc[bru_bleu] | op.opc[bru_ble];
   assign res.is_breg = op.opc[bru_jmpreg];
   assign res.is_brel = op.opc[bru_jmprel];
   assign is_jmp = op.opc[bru_jmpreg] | op.opc[bru_jmprel];

   // Conditional outcome, one term per opcode bit
   assign bcc_taken = (op.opc[bru_beq] & cmp_eq) |
                      (op.opc[bru_bne] & ~cmp_eq) |
                      (op.opc[bru_bgtu] & ~cmp_lt_u & ~cmp_eq) |
                      (op.opc[bru_bgt] & ~cmp_lt_s & ~cmp_eq) |
                      (op.opc[bru_bleu] & (cmp_lt_u | cmp_eq)) |
                      (op.opc[bru_ble] & (cmp_lt_s | cmp_eq));

   // Jumps are unconditional
   assign res.taken = bcc_taken | is_jmp;

   // Candidate targets in word units
   assign tgt_bcc = op.pc + op.imm[addr_w-1:insn_len_log2];
   assign tgt_rel = op.pc + op.operand2[addr_w-1:insn_len_log2];
   // Register jump, low bits dropped
   assign tgt_reg = op.operand1[addr_w-1:insn_len_log2];

   // Opcode is one-hot so the masked terms never overlap
   // Zero when nothing is taken
   assign res.tgt = ({pc_w{bcc_taken}} & tgt_bcc) |
                    ({pc_w{op.opc[bru_jmprel]}} & tgt_rel) |
                    ({pc_w{op.opc[bru_jmpreg]}} & tgt_reg);

   // Link only for jumps writing the RF
   assign res.link_valid = is_jmp & op.rf_we;
   // Next PC as byte address
   assign res.link_data = {op.pc + pc_t'(1), {insn_len_log2{1'b0}}};

   assign res.pc = op.pc;

endmodule

`default_nettype wire

/* hdl/ex_add.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_add
   import ncpu_ex_pkg::*;
(
   input wire data_t a,
   input wire data_t b,
   output data_t sum,
   output logic carry,
   output logic overflow
);

   // Widened by one bit to catch the carry out
   logic [data_w:0] diff;

   // a - b as a + ~b + 1
   assign diff = {1'b0, a} + {1'b0, ~b} + {{data_w{1'b0}}, 1'b1};
   assign sum = diff[data_w-1:0];

   // Set when a >= b unsigned, i.e. no borrow
   assign carry = diff[data_w];

   // Signs differ and result sign departs from a
   assign overflow = (a[data_w-1] ^ b[data_w-1]) & (a[data_w-1] ^ sum[data_w-1]);

endmodule

`default_nettype wire

/* hdl/ncpu_ex_pkg.sv */
`default_nettype none

package ncpu_ex_pkg;

   // Datapath widths fixed by the CPU configuration
   localparam int data_w = 32;
   localparam int addr_w = 32;
   // Instructions are 4 bytes
   localparam int insn_len_log2 = 2;
   // PC counts instruction words, not bytes
   localparam int pc_w = addr_w - insn_len_log2;

   // One-hot branch opcode bus
   localparam int bru_opc_w = 8;
   localparam int bru_beq = 0;
   localparam int bru_bne = 1;
   localparam int bru_bgtu = 2;
   localparam int bru_bgt = 3;
   localparam int bru_bleu = 4;
   localparam int bru_ble = 5;
   localparam int bru_jmpreg = 6;
   localparam int bru_jmprel = 7;

   // Result buffer depth
   localparam int buf_depth = 2;

   typedef logic [data_w-1:0] data_t;
   typedef logic [pc_w-1:0] pc_t;
   typedef logic [bru_opc_w-1:0] bru_opc_t;

   // Redirect sequencing in the control block
   typedef enum logic [0:0] {
      ctrl_run,
      ctrl_redirect
   } ctrl_state_t;

   // One branch-class operation from issue
   typedef struct packed {
      bru_opc_t opc;
      pc_t pc;
      data_t imm;
      data_t operand1;
      data_t operand2;
      logic rf_we;
   } ex_issue_t;

   // Resolved outcome
   typedef struct packed {
      pc_t pc;
      logic taken;
      pc_t tgt;
      logic is_bcc;
      logic is_breg;
      logic is_brel;
      logic link_valid;
      data_t link_data;
   } bru_result_t;

endpackage

`default_nettype wire
